//--- project.f
+incdir+sim
src/cluster_periph_pkg.sv
src/periph_bus_if.sv
src/periph_decoder.sv
src/cluster_ctrl_regs.sv
src/cluster_timer.sv
src/cluster_event_unit.sv
src/cluster_periph_top.sv
sim/tb_cluster_periph.sv

//--- sim/tb_cluster_periph_model.svh
`ifndef TB_CLUSTER_PERIPH_MODEL_SVH
`define TB_CLUSTER_PERIPH_MODEL_SVH

// ****************************************
// shadow registers
// ****************************************

logic                          sh_eoc;
cluster_periph_pkg::core_vec_t sh_fetch_en;
cluster_periph_pkg::word_t     sh_boot [cluster_periph_pkg::nb_cores];
cluster_periph_pkg::evt_vec_t  sh_mask [cluster_periph_pkg::nb_cores];
cluster_periph_pkg::evt_vec_t  sh_buf  [cluster_periph_pkg::nb_cores];

task automatic model_reset();
  sh_eoc      = 1'b0;
  sh_fetch_en = '0;
  for (int c = 0; c < cluster_periph_pkg::nb_cores; c++) begin
    sh_boot[c] = cluster_periph_pkg::boot_addr_rst;
    sh_mask[c] = '0;
    sh_buf[c]  = '0;
  end
endtask

function automatic cluster_periph_pkg::word_t merge_selected_bytes(
  input cluster_periph_pkg::word_t cur,
  input cluster_periph_pkg::word_t wdata,
  input cluster_periph_pkg::sel_t  sel
);
  cluster_periph_pkg::word_t res;
  for (int b = 0; b < 4; b++) begin
    res[8*b +: 8] = sel[b] ? wdata[8*b +: 8] : cur[8*b +: 8];
  end
  return res;
endfunction

// control unit, word 0 eoc, word 1 fetch enable, words 2.. boot addresses
task automatic model_ctrl_write(input cluster_periph_pkg::reg_idx_t idx,
                                input cluster_periph_pkg::word_t wdata,
                                input cluster_periph_pkg::sel_t sel);
  if (idx == 0 && sel[0]) begin
    sh_eoc = wdata[0];
  end else if (idx == 1 && sel[0]) begin
    sh_fetch_en = wdata[cluster_periph_pkg::nb_cores-1:0];
  end else if (idx >= 2 && idx < 2 + cluster_periph_pkg::nb_cores) begin
    sh_boot[idx-2] = merge_selected_bytes(sh_boot[idx-2], wdata, sel);
  end
endtask

function automatic cluster_periph_pkg::word_t model_ctrl_read(
  input cluster_periph_pkg::reg_idx_t idx
);
  if (idx == 0) begin
    return {31'd0, sh_eoc};
  end
  if (idx == 1) begin
    return {28'd0, sh_fetch_en};
  end
  if (idx >= 2 && idx < 2 + cluster_periph_pkg::nb_cores) begin
    return sh_boot[idx-2];
  end
  return '0;
endfunction

function automatic cluster_periph_pkg::evt_vec_t pending_events(input int c);
  return sh_buf[c] & sh_mask[c];
endfunction

function automatic cluster_periph_pkg::irq_id_t lowest_pending(input int c);
  cluster_periph_pkg::evt_vec_t pend;
  pend = pending_events(c);
  for (int b = 0; b < cluster_periph_pkg::nb_evt; b++) begin
    if (pend[b]) begin
      return cluster_periph_pkg::irq_id_t'(b);
    end
  end
  return '0;
endfunction

// one clock edge of the buffers, a set beats a clear
task automatic model_event_cycle(input cluster_periph_pkg::evt_vec_t evt_in,
                                 input cluster_periph_pkg::core_vec_t ack);
  cluster_periph_pkg::evt_vec_t clr;
  for (int c = 0; c < cluster_periph_pkg::nb_cores; c++) begin
    clr = '0;
    if (ack[c] && pending_events(c) != '0) begin
      clr[lowest_pending(c)] = 1'b1;
    end
    sh_buf[c] = (sh_buf[c] & ~clr) | evt_in;
  end
endtask

task automatic model_event_write(input cluster_periph_pkg::reg_idx_t idx,
                                 input cluster_periph_pkg::word_t wdata);
  // byte 0x20 raises software events in all cores
  if (idx == 8) begin
    for (int c = 0; c < cluster_periph_pkg::nb_cores; c++) begin
      sh_buf[c] = sh_buf[c] | {wdata[1:0], 6'd0};
    end
  end else if (idx < 2 * cluster_periph_pkg::nb_cores) begin
    if (idx[0]) begin
      sh_buf[idx/2] = sh_buf[idx/2] & ~wdata[7:0];
    end else begin
      sh_mask[idx/2] = wdata[7:0];
    end
  end
endtask

function automatic cluster_periph_pkg::word_t model_event_read(
  input cluster_periph_pkg::reg_idx_t idx
);
  if (idx < 2 * cluster_periph_pkg::nb_cores) begin
    return idx[0] ? {24'd0, sh_buf[idx/2]} : {24'd0, sh_mask[idx/2]};
  end
  return '0;
endfunction

`endif

//--- sim/tb_cluster_periph.sv
`timescale 1ns/1ps

module tb_cluster_periph;

  // rough number of bus accesses and event cycles, sizes the watchdog
  localparam int n_trans = 600;

  logic                          clk_i = 1'b0;
  logic                          rst_i;
  logic                          wb_cyc_i;
  logic                          wb_stb_i;
  logic                          wb_we_i;
  cluster_periph_pkg::addr_t     wb_adr_i;
  cluster_periph_pkg::word_t     wb_dat_i;
  cluster_periph_pkg::sel_t      wb_sel_i;
  cluster_periph_pkg::word_t     wb_dat_o;
  logic                          wb_ack_o;
  cluster_periph_pkg::core_vec_t core_busy_i;
  logic [3:0]                    hwpe_events_i;
  logic                          dma_event_i;
  cluster_periph_pkg::core_vec_t irq_ack_i;
  logic                          eoc_o;
  cluster_periph_pkg::core_vec_t fetch_enable_o;
  cluster_periph_pkg::word_t [cluster_periph_pkg::nb_cores-1:0] boot_addr_o;
  logic                          busy_o;
  cluster_periph_pkg::core_vec_t irq_req_o;
  cluster_periph_pkg::irq_id_t [cluster_periph_pkg::nb_cores-1:0] irq_id_o;
  cluster_periph_pkg::core_vec_t core_clk_en_o;

  int err_cnt  = 0;
  int seed     = 58;
  int cycle_no = 0;
  int ack_cycle;

  `include "tb_cluster_periph_model.svh"

  cluster_periph_top i_dut (
    .clk_i          ( clk_i          ),
    .rst_i          ( rst_i          ),
    .wb_cyc_i       ( wb_cyc_i       ),
    .wb_stb_i       ( wb_stb_i       ),
    .wb_we_i        ( wb_we_i        ),
    .wb_adr_i       ( wb_adr_i       ),
    .wb_dat_i       ( wb_dat_i       ),
    .wb_sel_i       ( wb_sel_i       ),
    .wb_dat_o       ( wb_dat_o       ),
    .wb_ack_o       ( wb_ack_o       ),
    .core_busy_i    ( core_busy_i    ),
    .hwpe_events_i  ( hwpe_events_i  ),
    .dma_event_i    ( dma_event_i    ),
    .irq_ack_i      ( irq_ack_i      ),
    .eoc_o          ( eoc_o          ),
    .fetch_enable_o ( fetch_enable_o ),
    .boot_addr_o    ( boot_addr_o    ),
    .busy_o         ( busy_o         ),
    .irq_req_o      ( irq_req_o      ),
    .irq_id_o       ( irq_id_o       ),
    .core_clk_en_o  ( core_clk_en_o  )
  );

  always #2 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycle_no <= cycle_no + 1;
  end

  function automatic int unsigned rand_below(input int unsigned n);
    return $unsigned($random(seed)) % n;
  endfunction

  task automatic check_val(input string name, input cluster_periph_pkg::word_t exp,
                           input cluster_periph_pkg::word_t got);
    assert (got === exp) else begin
      $display("ERROR: %s expected %h got %h", name, exp, got);
      err_cnt++;
    end
  endtask

  task automatic next_cycle();
    @(posedge clk_i);
    #1;
  endtask

  // ****************************************
  // wishbone master
  // ****************************************

  task automatic bus_access(input logic we, input cluster_periph_pkg::addr_t adr,
                            input cluster_periph_pkg::word_t wdata,
                            input cluster_periph_pkg::sel_t sel,
                            output cluster_periph_pkg::word_t rdata);
    int waited;
    waited   = 0;
    wb_cyc_i = 1'b1;
    wb_stb_i = 1'b1;
    wb_we_i  = we;
    wb_adr_i = adr;
    wb_dat_i = wdata;
    wb_sel_i = sel;
    do begin
      next_cycle();
      waited++;
    end while (!wb_ack_o && waited < 10);
    assert (wb_ack_o) else begin
      $display("no acknowledge for address %h after %0d cycles", adr, waited);
      err_cnt++;
    end
    assert (!wb_ack_o || waited == 2) else begin
      $display("acknowledge for address %h came after %0d cycles, not 2", adr, waited);
      err_cnt++;
    end
    rdata     = wb_dat_o;
    ack_cycle = cycle_no;
    wb_cyc_i  = 1'b0;
    wb_stb_i  = 1'b0;
    wb_we_i   = 1'b0;
    // decoder leaves its ack state
    next_cycle();
  endtask

  task automatic reg_write(input logic [1:0] blk, input cluster_periph_pkg::reg_idx_t idx,
                           input cluster_periph_pkg::word_t data,
                           input cluster_periph_pkg::sel_t sel);
    cluster_periph_pkg::word_t discard;
    bus_access(1'b1, {blk, idx, 2'b00}, data, sel, discard);
  endtask

  task automatic reg_read(input logic [1:0] blk, input cluster_periph_pkg::reg_idx_t idx,
                          output cluster_periph_pkg::word_t data);
    bus_access(1'b0, {blk, idx, 2'b00}, '0, 4'hf, data);
  endtask

  task automatic check_ctrl_outputs();
    check_val("eoc_o", sh_eoc, eoc_o);
    check_val("fetch_enable_o", sh_fetch_en, fetch_enable_o);
    for (int c = 0; c < cluster_periph_pkg::nb_cores; c++) begin
      check_val($sformatf("boot_addr_o[%0d]", c), sh_boot[c], boot_addr_o[c]);
    end
  endtask

  task automatic check_irq_outputs();
    cluster_periph_pkg::core_vec_t req_exp;
    for (int c = 0; c < cluster_periph_pkg::nb_cores; c++) begin
      req_exp[c] = (pending_events(c) != '0);
      check_val($sformatf("irq_req_o[%0d]", c), req_exp[c], irq_req_o[c]);
      if (req_exp[c]) begin
        check_val($sformatf("irq_id_o[%0d]", c), lowest_pending(c), irq_id_o[c]);
      end
    end
    check_val("core_clk_en_o", core_busy_i | req_exp, core_clk_en_o);
  endtask

  // event inputs live for one edge, then the model takes the same edge
  task automatic event_cycle(input logic dma, input logic [3:0] hwpe,
                             input cluster_periph_pkg::core_vec_t ack,
                             input cluster_periph_pkg::core_vec_t busy);
    dma_event_i   = dma;
    hwpe_events_i = hwpe;
    irq_ack_i     = ack;
    core_busy_i   = busy;
    next_cycle();
    dma_event_i   = 1'b0;
    hwpe_events_i = '0;
    irq_ack_i     = '0;
    model_event_cycle({2'b00, hwpe, dma, 1'b0}, ack);
    check_irq_outputs();
  endtask

  initial begin
    cluster_periph_pkg::word_t    rd;
    cluster_periph_pkg::word_t    wd;
    cluster_periph_pkg::word_t    cnt_a;
    cluster_periph_pkg::word_t    cmp;
    cluster_periph_pkg::sel_t     sel;
    cluster_periph_pkg::reg_idx_t idx;
    int                           cyc_a;
    int                           core;
    int                           waited;
    rst_i         = 1'b1;
    wb_cyc_i      = 1'b0;
    wb_stb_i      = 1'b0;
    wb_we_i       = 1'b0;
    wb_adr_i      = '0;
    wb_dat_i      = '0;
    wb_sel_i      = '0;
    core_busy_i   = '0;
    hwpe_events_i = '0;
    dma_event_i   = 1'b0;
    irq_ack_i     = '0;
    model_reset();
    repeat (4) @(posedge clk_i);
    #1;
    rst_i = 1'b0;

    // ****************************************
    // reset values
    // ****************************************
    check_val("wb_ack_o", 0, wb_ack_o);
    check_val("busy_o", 0, busy_o);
    check_ctrl_outputs();
    check_irq_outputs();
    for (int i = 0; i < 6; i++) begin
      reg_read(cluster_periph_pkg::blk_ctrl, i, rd);
      check_val("wb_dat_o", model_ctrl_read(i), rd);
    end
    for (int i = 0; i < 3; i++) begin
      reg_read(cluster_periph_pkg::blk_timer, i, rd);
      check_val("wb_dat_o", 0, rd);
    end
    for (int i = 0; i < 8; i++) begin
      reg_read(cluster_periph_pkg::blk_event, i, rd);
      check_val("wb_dat_o", 0, rd);
    end

    // control registers with random byte selects
    for (int i = 0; i < 200; i++) begin
      idx = rand_below(8);
      wd  = $random(seed);
      sel = rand_below(16);
      if (rand_below(2) == 0) begin
        reg_write(cluster_periph_pkg::blk_ctrl, idx, wd, sel);
        model_ctrl_write(idx, wd, sel);
      end else begin
        reg_read(cluster_periph_pkg::blk_ctrl, idx, rd);
        check_val("wb_dat_o", model_ctrl_read(idx), rd);
      end
      if (rand_below(8) == 0) begin
        reg_write(2'd3, idx, wd, 4'hf);
        reg_read(2'd3, idx, rd);
        check_val("wb_dat_o", 0, rd);
      end
      check_ctrl_outputs();
    end

    // ****************************************
    // timer
    // ****************************************
    core = rand_below(cluster_periph_pkg::nb_cores);
    cmp  = 20 + rand_below(80);
    reg_write(cluster_periph_pkg::blk_timer, 2, cmp, 4'hf);
    reg_write(cluster_periph_pkg::blk_event, 2 * core, 32'h1, 4'hf);
    reg_write(cluster_periph_pkg::blk_timer, 0, 32'h7, 4'hf);
    check_val("busy_o", 1, busy_o);
    waited = 0;
    while (!irq_req_o[core] && waited < cmp + 50) begin
      next_cycle();
      waited++;
    end
    assert (irq_req_o[core]) else begin
      $display("timer match raised no interrupt on core %0d", core);
      err_cnt++;
    end
    check_val($sformatf("irq_id_o[%0d]", core), 0, irq_id_o[core]);
    for (int i = 0; i < 6; i++) begin
      reg_read(cluster_periph_pkg::blk_timer, 1, rd);
      assert (rd <= cmp) else begin
        $display("ERROR: wb_dat_o count %h above compare %h", rd, cmp);
        err_cnt++;
      end
      repeat (rand_below(30)) next_cycle();
    end
    // free running, no clear on match
    reg_write(cluster_periph_pkg::blk_timer, 0, 32'h1, 4'hf);
    reg_read(cluster_periph_pkg::blk_timer, 1, cnt_a);
    cyc_a = ack_cycle;
    repeat (rand_below(40)) next_cycle();
    reg_read(cluster_periph_pkg::blk_timer, 1, rd);
    check_val("wb_dat_o", cnt_a + (ack_cycle - cyc_a), rd);
    reg_write(cluster_periph_pkg::blk_timer, 0, 32'h0, 4'hf);
    check_val("busy_o", 0, busy_o);
    for (int c = 0; c < cluster_periph_pkg::nb_cores; c++) begin
      reg_write(cluster_periph_pkg::blk_event, 2 * c, 32'h0, 4'hf);
      reg_write(cluster_periph_pkg::blk_event, 2 * c + 1, 32'hff, 4'hf);
      sh_mask[c] = '0;
      sh_buf[c]  = '0;
    end
    check_irq_outputs();

    // ****************************************
    // events and interrupts
    // ****************************************
    for (int c = 0; c < cluster_periph_pkg::nb_cores; c++) begin
      wd = rand_below(256);
      reg_write(cluster_periph_pkg::blk_event, 2 * c, wd, 4'hf);
      model_event_write(2 * c, wd);
    end
    for (int i = 0; i < 200; i++) begin
      case (rand_below(10))
        0: begin
          wd = rand_below(4);
          reg_write(cluster_periph_pkg::blk_event, 8, wd, 4'hf);
          model_event_write(8, wd);
        end
        1, 3: begin
          wd  = rand_below(256);
          idx = 2 * rand_below(cluster_periph_pkg::nb_cores) + (i % 2);
          reg_write(cluster_periph_pkg::blk_event, idx, wd, 4'hf);
          model_event_write(idx, wd);
        end
        2: begin
          idx = rand_below(10);
          reg_read(cluster_periph_pkg::blk_event, idx, rd);
          check_val("wb_dat_o", model_event_read(idx), rd);
        end
        default: event_cycle(rand_below(2), rand_below(16), rand_below(16), core_busy_i);
      endcase
      check_irq_outputs();
    end

    // clock enable with busy changing every cycle
    for (int i = 0; i < 100; i++) begin
      event_cycle(rand_below(4) == 0, 4'h0, rand_below(16) & rand_below(16), rand_below(16));
    end

    $display("run complete with %0d errors", err_cnt);
    if (err_cnt == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

  initial begin
    repeat (n_trans * 10 + 1000) @(posedge clk_i);
    $display("watchdog expired before the tests finished, %0d errors so far", err_cnt);
    $display("Test FAILED");
    $finish;
  end

endmodule

//--- src/cluster_ctrl_regs.sv
`timescale 1ns/1ps

module cluster_ctrl_regs (
  input  logic                          clk_i,
  input  logic                          rst_i,
  periph_bus_if.slave                   bus_i,
  output logic                          eoc_o,
  output cluster_periph_pkg::core_vec_t fetch_enable_o,
  output cluster_periph_pkg::word_t [cluster_periph_pkg::nb_cores-1:0] boot_addr_o
);

  logic                          eoc_q;
  cluster_periph_pkg::core_vec_t fe_q;
  cluster_periph_pkg::word_t [cluster_periph_pkg::nb_cores-1:0] boot_q;
  logic                          wr_en;

  // replace only the bytes that are selected
  function automatic cluster_periph_pkg::word_t byte_merge(
    input cluster_periph_pkg::word_t old_val,
    input cluster_periph_pkg::word_t new_val,
    input cluster_periph_pkg::sel_t  sel
  );
    cluster_periph_pkg::word_t res;
    res = old_val;
    for (int b = 0; b < 4; b++) begin
      if (sel[b]) begin
        res[8*b +: 8] = new_val[8*b +: 8];
      end
    end
    return res;
  endfunction

  assign wr_en = bus_i.stb && bus_i.we;

  // ****************************************
  // register writes
  // ****************************************

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      eoc_q <= 1'b0;
      fe_q  <= '0;
      for (int c = 0; c < cluster_periph_pkg::nb_cores; c++) begin
        boot_q[c] <= cluster_periph_pkg::boot_addr_rst;
      end
    end else if (wr_en) begin
      // eoc and fetch enable sit in byte 0
      if (bus_i.idx == 6'd0 && bus_i.sel[0]) begin
        eoc_q <= bus_i.wdata[0];
      end
      if (bus_i.idx == 6'd1 && bus_i.sel[0]) begin
        fe_q <= bus_i.wdata[cluster_periph_pkg::nb_cores-1:0];
      end
      for (int c = 0; c < cluster_periph_pkg::nb_cores; c++) begin
        if (bus_i.idx == cluster_periph_pkg::reg_idx_t'(2 + c)) begin
          boot_q[c] <= byte_merge(boot_q[c], bus_i.wdata, bus_i.sel);
        end
      end
    end
  end

  // read back, unused words give zero
  always_comb begin
    bus_i.rdata = '0;
    if (bus_i.idx == 6'd0) begin
      bus_i.rdata[0] = eoc_q;
    end else if (bus_i.idx == 6'd1) begin
      bus_i.rdata[cluster_periph_pkg::nb_cores-1:0] = fe_q;
    end else begin
      for (int c = 0; c < cluster_periph_pkg::nb_cores; c++) begin
        if (bus_i.idx == cluster_periph_pkg::reg_idx_t'(2 + c)) begin
          bus_i.rdata = boot_q[c];
        end
      end
    end
  end

  assign eoc_o          = eoc_q;
  assign fetch_enable_o = fe_q;
  assign boot_addr_o    = boot_q;

endmodule

//--- src/cluster_event_unit.sv
`timescale 1ns/1ps

module cluster_event_unit (
  input  logic                          clk_i,
  input  logic                          rst_i,
  periph_bus_if.slave                   bus_i,
  input  logic                          timer_evt_i,
  input  logic                          dma_event_i,
  input  logic [3:0]                    hwpe_events_i,
  input  cluster_periph_pkg::core_vec_t core_busy_i,
  input  cluster_periph_pkg::core_vec_t irq_ack_i,
  output cluster_periph_pkg::core_vec_t irq_req_o,
  output cluster_periph_pkg::irq_id_t [cluster_periph_pkg::nb_cores-1:0] irq_id_o,
  output cluster_periph_pkg::core_vec_t core_clk_en_o
);

  cluster_periph_pkg::evt_vec_t [cluster_periph_pkg::nb_cores-1:0] mask_q;
  cluster_periph_pkg::evt_vec_t [cluster_periph_pkg::nb_cores-1:0] buf_q;
  cluster_periph_pkg::evt_vec_t [cluster_periph_pkg::nb_cores-1:0] clr;
  cluster_periph_pkg::evt_vec_t [cluster_periph_pkg::nb_cores-1:0] pend;
  cluster_periph_pkg::evt_vec_t evt_in;
  logic [1:0]                   sw_evt;
  logic                         wr_en;

  assign wr_en = bus_i.stb && bus_i.we;

  // software events go to every core
  assign sw_evt = (wr_en && bus_i.idx == cluster_periph_pkg::evt_sw_idx) ?
                  bus_i.wdata[1:0] : 2'b00;

  assign evt_in = {sw_evt, hwpe_events_i, dma_event_i, timer_evt_i};

  // ****************************************
  // buffer clear sources
  // ****************************************

  // write one to clear, plus the bit being acknowledged
  always_comb begin
    for (int c = 0; c < cluster_periph_pkg::nb_cores; c++) begin
      clr[c] = '0;
      if (wr_en && bus_i.idx == cluster_periph_pkg::reg_idx_t'(2 * c + 1)) begin
        clr[c] = bus_i.wdata[cluster_periph_pkg::nb_evt-1:0];
      end
      if (irq_ack_i[c] && irq_req_o[c]) begin
        clr[c][irq_id_o[c]] = 1'b1;
      end
    end
  end

  // ****************************************
  // masks and event buffers
  // ****************************************

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      mask_q <= '0;
      buf_q  <= '0;
    end else begin
      for (int c = 0; c < cluster_periph_pkg::nb_cores; c++) begin
        if (wr_en && bus_i.idx == cluster_periph_pkg::reg_idx_t'(2 * c)) begin
          mask_q[c] <= bus_i.wdata[cluster_periph_pkg::nb_evt-1:0];
        end
        // a new event beats a clear of the same bit
        buf_q[c] <= (buf_q[c] & ~clr[c]) | evt_in;
      end
    end
  end

  // ****************************************
  // interrupt selection
  // ****************************************

  // lowest pending masked event wins
  always_comb begin
    for (int c = 0; c < cluster_periph_pkg::nb_cores; c++) begin
      pend[c]      = buf_q[c] & mask_q[c];
      irq_req_o[c] = |pend[c];
      irq_id_o[c]  = '0;
      for (int b = cluster_periph_pkg::nb_evt - 1; b >= 0; b--) begin
        if (pend[c][b]) begin
          irq_id_o[c] = cluster_periph_pkg::irq_id_t'(b);
        end
      end
    end
  end

  // core keeps its clock while busy or while an interrupt waits
  assign core_clk_en_o = core_busy_i | irq_req_o;

  // mask on even words, buffer on odd words
  always_comb begin
    bus_i.rdata = '0;
    if (bus_i.idx < cluster_periph_pkg::reg_idx_t'(2 * cluster_periph_pkg::nb_cores)) begin
      if (bus_i.idx[0]) begin
        bus_i.rdata[cluster_periph_pkg::nb_evt-1:0] = buf_q[bus_i.idx[5:1]];
      end else begin
        bus_i.rdata[cluster_periph_pkg::nb_evt-1:0] = mask_q[bus_i.idx[5:1]];
      end
    end
  end

endmodule

//--- src/cluster_periph_pkg.sv
package cluster_periph_pkg;

  // ****************************************
  // cluster configuration
  // ****************************************

  localparam int unsigned nb_cores = 4;
  localparam int unsigned nb_evt   = 8;

  localparam logic [31:0] boot_addr_rst = 32'h1C00_0000;

  // block numbers taken from address bits 9:8, block 3 is unmapped
  localparam logic [1:0] blk_ctrl  = 2'd0;
  localparam logic [1:0] blk_timer = 2'd1;
  localparam logic [1:0] blk_event = 2'd2;

  // software event register word in the event unit (byte 0x20)
  localparam logic [5:0] evt_sw_idx = 6'd8;

  // ****************************************
  // types
  // ****************************************

  typedef logic [31:0] word_t;
  typedef logic [9:0]  addr_t;

  // word index inside a block, address bits 7:2
  typedef logic [5:0]  reg_idx_t;
  typedef logic [3:0]  sel_t;

  typedef logic [nb_cores-1:0] core_vec_t;

  // bit 0 timer, bit 1 dma, bits 5:2 accelerator, bits 7:6 software
  typedef logic [nb_evt-1:0] evt_vec_t;
  typedef logic [2:0]        irq_id_t;

  typedef enum logic {
    bus_idle,
    bus_ack
  } bus_state_e;

endpackage

//--- src/cluster_periph_top.sv
`timescale 1ns/1ps

module cluster_periph_top (
  input  logic                          clk_i,
  input  logic                          rst_i,

  // wishbone slave
  input  logic                          wb_cyc_i,
  input  logic                          wb_stb_i,
  input  logic                          wb_we_i,
  input  cluster_periph_pkg::addr_t     wb_adr_i,
  input  cluster_periph_pkg::word_t     wb_dat_i,
  input  cluster_periph_pkg::sel_t      wb_sel_i,
  output cluster_periph_pkg::word_t     wb_dat_o,
  output logic                          wb_ack_o,

  // core side
  input  cluster_periph_pkg::core_vec_t core_busy_i,
  input  logic [3:0]                    hwpe_events_i,
  input  logic                          dma_event_i,
  input  cluster_periph_pkg::core_vec_t irq_ack_i,
  output logic                          eoc_o,
  output cluster_periph_pkg::core_vec_t fetch_enable_o,
  output cluster_periph_pkg::word_t [cluster_periph_pkg::nb_cores-1:0] boot_addr_o,
  output logic                          busy_o,
  output cluster_periph_pkg::core_vec_t irq_req_o,
  output cluster_periph_pkg::irq_id_t [cluster_periph_pkg::nb_cores-1:0] irq_id_o,
  output cluster_periph_pkg::core_vec_t core_clk_en_o
);

  logic timer_evt;

  periph_bus_if ctrl_bus ();
  periph_bus_if timer_bus ();
  periph_bus_if event_bus ();

  // ****************************************
  // bus split
  // ****************************************

  periph_decoder i_decoder (
    .clk_i       ( clk_i     ),
    .rst_i       ( rst_i     ),
    .wb_cyc_i    ( wb_cyc_i  ),
    .wb_stb_i    ( wb_stb_i  ),
    .wb_we_i     ( wb_we_i   ),
    .wb_adr_i    ( wb_adr_i  ),
    .wb_dat_i    ( wb_dat_i  ),
    .wb_sel_i    ( wb_sel_i  ),
    .wb_dat_o    ( wb_dat_o  ),
    .wb_ack_o    ( wb_ack_o  ),
    .ctrl_bus_o  ( ctrl_bus  ),
    .timer_bus_o ( timer_bus ),
    .event_bus_o ( event_bus )
  );

  // ****************************************
  // register blocks
  // ****************************************

  cluster_ctrl_regs i_ctrl (
    .clk_i          ( clk_i          ),
    .rst_i          ( rst_i          ),
    .bus_i          ( ctrl_bus       ),
    .eoc_o          ( eoc_o          ),
    .fetch_enable_o ( fetch_enable_o ),
    .boot_addr_o    ( boot_addr_o    )
  );

  cluster_timer i_timer (
    .clk_i       ( clk_i     ),
    .rst_i       ( rst_i     ),
    .bus_i       ( timer_bus ),
    .timer_evt_o ( timer_evt ),
    .busy_o      ( busy_o    )
  );

  cluster_event_unit i_event_unit (
    .clk_i         ( clk_i         ),
    .rst_i         ( rst_i         ),
    .bus_i         ( event_bus     ),
    .timer_evt_i   ( timer_evt     ),
    .dma_event_i   ( dma_event_i   ),
    .hwpe_events_i ( hwpe_events_i ),
    .core_busy_i   ( core_busy_i   ),
    .irq_ack_i     ( irq_ack_i     ),
    .irq_req_o     ( irq_req_o     ),
    .irq_id_o      ( irq_id_o      ),
    .core_clk_en_o ( core_clk_en_o )
  );

endmodule

//--- src/cluster_timer.sv
`timescale 1ns/1ps

module cluster_timer (
  input  logic        clk_i,
  input  logic        rst_i,
  periph_bus_if.slave bus_i,
  output logic        timer_evt_o,
  output logic        busy_o
);

  // cfg_q bit 0 enable, bit 1 event enable, bit 2 clear on match
  logic [2:0]                cfg_q;
  cluster_periph_pkg::word_t count_q;
  cluster_periph_pkg::word_t cmp_q;
  logic                      wr_en;
  logic                      match;

  assign wr_en = bus_i.stb && bus_i.we;

  // only a running counter can match
  assign match = cfg_q[0] && (count_q == cmp_q);

  // ****************************************
  // configuration and compare
  // ****************************************

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      cfg_q <= '0;
      cmp_q <= '0;
    end else if (wr_en) begin
      if (bus_i.idx == 6'd0) begin
        cfg_q <= bus_i.wdata[2:0];
      end
      if (bus_i.idx == 6'd2) begin
        cmp_q <= bus_i.wdata;
      end
    end
  end

  // ****************************************
  // counter
  // ****************************************

  // bus write wins over counting
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      count_q <= '0;
    end else if (wr_en && bus_i.idx == 6'd1) begin
      count_q <= bus_i.wdata;
    end else if (cfg_q[0]) begin
      if (match && cfg_q[2]) begin
        count_q <= '0;
      end else begin
        count_q <= count_q + 32'd1;
      end
    end
  end

  // one pulse per match
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      timer_evt_o <= 1'b0;
    end else begin
      timer_evt_o <= match && cfg_q[1];
    end
  end

  always_comb begin
    case (bus_i.idx)
      6'd0:    bus_i.rdata = {29'd0, cfg_q};
      6'd1:    bus_i.rdata = count_q;
      6'd2:    bus_i.rdata = cmp_q;
      default: bus_i.rdata = '0;
    endcase
  end

  assign busy_o = cfg_q[0];

endmodule

//--- src/periph_bus_if.sv
`timescale 1ns/1ps

// one register block bus behind the address decoder
interface periph_bus_if;

  // single cycle access strobe
  logic                         stb;
  logic                         we;
  cluster_periph_pkg::reg_idx_t idx;
  cluster_periph_pkg::word_t    wdata;
  cluster_periph_pkg::sel_t     sel;

  // combinational read data from idx
  cluster_periph_pkg::word_t    rdata;

  modport master (
    output stb,
    output we,
    output idx,
    output wdata,
    output sel,
    input  rdata
  );

  modport slave (
    input  stb,
    input  we,
    input  idx,
    input  wdata,
    input  sel,
    output rdata
  );

endinterface

//--- src/periph_decoder.sv
`timescale 1ns/1ps

module periph_decoder (
  input  logic                      clk_i,
  input  logic                      rst_i,
  input  logic                      wb_cyc_i,
  input  logic                      wb_stb_i,
  input  logic                      wb_we_i,
  input  cluster_periph_pkg::addr_t wb_adr_i,
  input  cluster_periph_pkg::word_t wb_dat_i,
  input  cluster_periph_pkg::sel_t  wb_sel_i,
  output cluster_periph_pkg::word_t wb_dat_o,
  output logic                      wb_ack_o,
  periph_bus_if.master              ctrl_bus_o,
  periph_bus_if.master              timer_bus_o,
  periph_bus_if.master              event_bus_o
);

  cluster_periph_pkg::bus_state_e state_q;
  logic                           stb_q;
  logic [1:0]                     blk_q;
  logic                           we_q;
  cluster_periph_pkg::reg_idx_t   idx_q;
  cluster_periph_pkg::word_t      wdata_q;
  cluster_periph_pkg::sel_t       sel_q;
  cluster_periph_pkg::word_t      rdata_mux;

  // ****************************************
  // handshake FSM
  // ****************************************

  // ack state covers the strobe cycle and the ack cycle
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q  <= cluster_periph_pkg::bus_idle;
      stb_q    <= 1'b0;
      wb_ack_o <= 1'b0;
    end else begin
      stb_q    <= 1'b0;
      wb_ack_o <= 1'b0;
      case (state_q)
        cluster_periph_pkg::bus_idle: begin
          if (wb_cyc_i && wb_stb_i) begin
            stb_q   <= 1'b1;
            state_q <= cluster_periph_pkg::bus_ack;
          end
        end
        default: begin
          if (wb_ack_o) begin
            state_q <= cluster_periph_pkg::bus_idle;
          end else begin
            wb_ack_o <= 1'b1;
          end
        end
      endcase
    end
  end

  // request fields, held while the access is in flight
  always_ff @(posedge clk_i) begin
    if (state_q == cluster_periph_pkg::bus_idle) begin
      blk_q   <= wb_adr_i[9:8];
      idx_q   <= wb_adr_i[7:2];
      we_q    <= wb_we_i;
      wdata_q <= wb_dat_i;
      sel_q   <= wb_sel_i;
    end
    if (stb_q) begin
      wb_dat_o <= rdata_mux;
    end
  end

  always_comb begin
    case (blk_q)
      cluster_periph_pkg::blk_ctrl:  rdata_mux = ctrl_bus_o.rdata;
      cluster_periph_pkg::blk_timer: rdata_mux = timer_bus_o.rdata;
      cluster_periph_pkg::blk_event: rdata_mux = event_bus_o.rdata;
      default:                       rdata_mux = '0;
    endcase
  end

  // ****************************************
  // block buses
  // ****************************************

  assign ctrl_bus_o.stb   = stb_q && (blk_q == cluster_periph_pkg::blk_ctrl);
  assign ctrl_bus_o.we    = we_q;
  assign ctrl_bus_o.idx   = idx_q;
  assign ctrl_bus_o.wdata = wdata_q;
  assign ctrl_bus_o.sel   = sel_q;

  assign timer_bus_o.stb   = stb_q && (blk_q == cluster_periph_pkg::blk_timer);
  assign timer_bus_o.we    = we_q;
  assign timer_bus_o.idx   = idx_q;
  assign timer_bus_o.wdata = wdata_q;
  assign timer_bus_o.sel   = sel_q;

  assign event_bus_o.stb   = stb_q && (blk_q == cluster_periph_pkg::blk_event);
  assign event_bus_o.we    = we_q;
  assign event_bus_o.idx   = idx_q;
  assign event_bus_o.wdata = wdata_q;
  assign event_bus_o.sel   = sel_q;

endmodule
